/* src/tage_pkg.sv */
package tage_pkg;

    ////////////////////
    // Table geometry
    ////////////////////

    // Number of tagged banks
    localparam int num_banks = 4;
    // 128 entries per bank
    localparam int index_bits = 7;
    // Partial tag stored per entry
    localparam int tag_bits = 8;
    // Prediction counter, upper half means taken
    localparam int ctr_bits = 3;
    localparam int useful_bits = 2;
    // Global history width from the caller
    localparam int hist_bits = 80;
    localparam int bank_id_bits = $clog2(num_banks);

    // History length per bank, shortest first
    localparam int hist_len [num_banks] = '{10, 20, 40, 80};

    ////////////////////
    // Field types
    ////////////////////

    typedef logic [index_bits-1:0]   index_t;
    typedef logic [tag_bits-1:0]     tag_t;
    typedef logic [ctr_bits-1:0]     ctr_t;
    typedef logic [useful_bits-1:0]  useful_t;
    typedef logic [bank_id_bits-1:0] bank_id_t;

    // Initial counter values for a fresh allocation
    localparam ctr_t ctr_weak_taken = ctr_t'(1 << (ctr_bits - 1));
    localparam ctr_t ctr_weak_not_taken = ctr_t'((1 << (ctr_bits - 1)) - 1);

    ////////////////////
    // Structs
    ////////////////////

    // One bank entry, 13 bits
    typedef struct packed {
        tag_t    tag;
        ctr_t    ctr;
        useful_t useful;
    } tage_entry_t;

    // Registered bank read plus tag match
    typedef struct packed {
        tage_entry_t entry;
        logic        hit;
    } tage_read_t;

    // Lookup snapshot carried to commit and back
    typedef struct packed {
        index_t  [num_banks-1:0] index;
        tag_t    [num_banks-1:0] tag;
        ctr_t    [num_banks-1:0] ctr;
        useful_t [num_banks-1:0] useful;
        bank_id_t                provider;
        logic                    provider_valid;
        bank_id_t                alt;
        logic                    alt_valid;
        logic                    alt_taken;
        logic                    pred_taken;
    } tage_pred_t;

    // Commit record with the resolved direction
    typedef struct packed {
        logic       valid;
        logic       taken;
        tage_pred_t pred;
    } tage_update_t;

    // Per-bank write command from the updater
    typedef struct packed {
        logic        we;
        logic        dec_useful;
        index_t      index;
        tage_entry_t entry;
    } tage_write_t;

endpackage

/* src/tage_fold_hash.sv */
`timescale 1ns/1ps

module tage_fold_hash #(
    parameter int HIST_LEN = 10
) (
    input  logic [31:0]                    pc,
    input  logic [tage_pkg::hist_bits-1:0] ghist,
    output tage_pkg::index_t               index,
    output tage_pkg::tag_t                 tag
);

    // Width of the second tag folding, one short of the tag
    localparam int tag_alt_bits = tage_pkg::tag_bits - 1;
    // Pc slice offsets
    localparam int idx_lsb = 2;
    localparam int tag_lsb = idx_lsb + tage_pkg::index_bits;

    // History folded to index width
    tage_pkg::index_t fold_idx;
    // History folded to tag width
    tage_pkg::tag_t fold_tag;
    // Second folding at a different width
    logic [tag_alt_bits-1:0] fold_tag_alt;

    ////////////////////
    // History folding
    ////////////////////

    // XOR each history bit into its chunk position
    // Only the first HIST_LEN bits take part
    always_comb begin
        fold_idx = '0;
        fold_tag = '0;
        fold_tag_alt = '0;
        for (int i = 0; i < HIST_LEN; i++) begin
            fold_idx[i % tage_pkg::index_bits] ^= ghist[i];
            fold_tag[i % tage_pkg::tag_bits] ^= ghist[i];
            fold_tag_alt[i % tag_alt_bits] ^= ghist[i];
        end
    end

    ////////////////////
    // Pc mixing
    ////////////////////

    // Index from the pc bits just above the word offset
    assign index = pc[idx_lsb +: tage_pkg::index_bits] ^ fold_idx;

    // Tag from the next pc slice
    // Second folding shifted up one so the two do not cancel
    assign tag = pc[tag_lsb +: tage_pkg::tag_bits]
               ^ fold_tag
               ^ {fold_tag_alt, 1'b0};

endmodule

/* src/tage_bank.sv */
`timescale 1ns/1ps

module tage_bank (
    input  logic                  clk,
    input  logic                  reset,
    input  tage_pkg::index_t      rd_index,
    input  tage_pkg::tag_t        rd_tag,
    output tage_pkg::tage_read_t  rd,
    input  tage_pkg::tage_write_t wr,
    input  logic                  age_hi,
    input  logic                  age_lo
);

    localparam int depth = 1 << tage_pkg::index_bits;
    localparam int ubit_hi = tage_pkg::useful_bits - 1;

    // Entry storage
    tage_pkg::tage_entry_t mem [depth];

    // Read stage registers
    tage_pkg::tage_entry_t rd_entry_q;
    tage_pkg::tag_t        rd_tag_q;

    ////////////////////
    // Read port
    ////////////////////

    // Registered read
    // Same-edge write is not visible here
    always_ff @(posedge clk) begin
        rd_entry_q <= mem[rd_index];
        rd_tag_q <= rd_tag;
    end

    assign rd.entry = rd_entry_q;

    // Tag zero marks an empty entry and never hits
    assign rd.hit = (rd_tag_q != '0) && (rd_entry_q.tag == rd_tag_q);

    ////////////////////
    // Write port and aging
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            // Whole table starts empty
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // Full entry write
            if (wr.we) begin
                mem[wr.index] <= wr.entry;
            end else if (wr.dec_useful && (mem[wr.index].useful != '0)) begin
                // Useful-only decrement, saturating at zero
                mem[wr.index].useful <= mem[wr.index].useful - 1'b1;
            end

            // Aging clear comes after the write so it also hits
            // an entry written on the same edge
            if (age_hi || age_lo) begin
                for (int i = 0; i < depth; i++) begin
                    if (age_hi) begin
                        mem[i].useful[ubit_hi] <= 1'b0;
                    end
                    if (age_lo) begin
                        mem[i].useful[0] <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

/* src/tage_select.sv */
`timescale 1ns/1ps

module tage_select (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              lookup_valid,
    input  tage_pkg::tage_read_t [tage_pkg::num_banks-1:0]    rd,
    input  tage_pkg::index_t     [tage_pkg::num_banks-1:0]    index,
    input  tage_pkg::tag_t       [tage_pkg::num_banks-1:0]    tag,
    output logic                                              pred_valid,
    output tage_pkg::tage_pred_t                              pred_out
);

    localparam int top_bit = tage_pkg::ctr_bits - 1;

    // Lookup index and tag aligned with the bank read stage
    tage_pkg::index_t [tage_pkg::num_banks-1:0] index_q;
    tage_pkg::tag_t   [tage_pkg::num_banks-1:0] tag_q;

    tage_pkg::bank_id_t provider;
    tage_pkg::bank_id_t alt;
    logic               provider_valid;
    logic               alt_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        index_q <= index;
        tag_q <= tag;
    end

    ////////////////////
    // Provider and alternate
    ////////////////////

    // Ascending scan so the highest hit wins
    always_comb begin
        provider = '0;
        provider_valid = 1'b0;
        alt = '0;
        alt_valid = 1'b0;
        for (int b = 0; b < tage_pkg::num_banks; b++) begin
            if (rd[b].hit) begin
                provider = tage_pkg::bank_id_t'(b);
                provider_valid = 1'b1;
            end
        end
        // Next longest hit strictly below the provider
        for (int b = 0; b < tage_pkg::num_banks; b++) begin
            if (rd[b].hit && provider_valid && (b < int'(provider))) begin
                alt = tage_pkg::bank_id_t'(b);
                alt_valid = 1'b1;
            end
        end
    end

    ////////////////////
    // Snapshot
    ////////////////////

    always_comb begin
        pred_out = '0;
        pred_out.index = index_q;
        pred_out.tag = tag_q;
        // Entry fields are kept even without a hit for allocation
        for (int b = 0; b < tage_pkg::num_banks; b++) begin
            pred_out.ctr[b] = rd[b].entry.ctr;
            pred_out.useful[b] = rd[b].entry.useful;
        end
        pred_out.provider = provider;
        pred_out.provider_valid = provider_valid;
        pred_out.alt = alt;
        pred_out.alt_valid = alt_valid;
        // No base predictor so a miss means not taken
        pred_out.alt_taken = alt_valid && rd[alt].entry.ctr[top_bit];
        pred_out.pred_taken = provider_valid && rd[provider].entry.ctr[top_bit];
    end

endmodule

/* src/tage_update.sv */
`timescale 1ns/1ps

module tage_update #(
    parameter int         UBIT_PERIOD_LOG = 8,
    parameter logic [7:0] LFSR_SEED = 8'hff
) (
    input  logic                                            clk,
    input  logic                                            reset,
    input  tage_pkg::tage_update_t                          upd,
    output tage_pkg::tage_write_t [tage_pkg::num_banks-1:0] wr,
    output logic                                            age_hi,
    output logic                                            age_lo
);

    // Roughly two thirds chance to pick the second candidate
    localparam logic [7:0] pick_second_below = 8'd170;
    localparam int last_bank = tage_pkg::num_banks - 1;

    logic [7:0]                 lfsr;
    logic                       lfsr_fb;
    logic [UBIT_PERIOD_LOG-1:0] age_cnt;
    // Low clears the high bit on the next wrap
    logic                       age_phase;
    logic                       age_wrap;

    tage_pkg::tage_pred_t snap;
    tage_pkg::ctr_t       prov_ctr;
    tage_pkg::ctr_t       new_ctr;
    tage_pkg::useful_t    prov_useful;
    tage_pkg::useful_t    new_useful;
    logic                 mispred;
    logic                 alloc_en;
    logic [tage_pkg::num_banks-1:0] above;
    logic [tage_pkg::num_banks-1:0] cand;
    logic                 first_found;
    logic                 second_found;
    tage_pkg::bank_id_t   first_cand;
    tage_pkg::bank_id_t   second_cand;
    tage_pkg::bank_id_t   alloc_bank;
    tage_pkg::tage_write_t [tage_pkg::num_banks-1:0] wr_d;

    assign snap = upd.pred;
    assign prov_ctr = snap.ctr[snap.provider];
    assign prov_useful = snap.useful[snap.provider];
    assign mispred = (upd.taken != snap.pred_taken);

    // Fibonacci taps 8 6 5 4
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
    assign age_wrap = upd.valid && (&age_cnt);

    ////////////////////
    // Provider training
    ////////////////////

    always_comb begin
        // Counter saturates toward the outcome
        new_ctr = prov_ctr;
        if (upd.taken && (prov_ctr != '1)) begin
            new_ctr = prov_ctr + 1'b1;
        end else if (!upd.taken && (prov_ctr != '0)) begin
            new_ctr = prov_ctr - 1'b1;
        end
        // Useful moves only when the alternate disagreed
        new_useful = prov_useful;
        if (snap.alt_taken != snap.pred_taken) begin
            if (!mispred && (prov_useful != '1)) begin
                new_useful = prov_useful + 1'b1;
            end else if (mispred && (prov_useful != '0)) begin
                new_useful = prov_useful - 1'b1;
            end
        end
    end

    ////////////////////
    // Allocation choice
    ////////////////////

    // Nothing longer to allocate into above the last bank
    assign alloc_en = upd.valid && mispred
                   && !(snap.provider_valid && (int'(snap.provider) == last_bank));

    always_comb begin
        first_found = 1'b0;
        second_found = 1'b0;
        first_cand = '0;
        second_cand = '0;
        for (int b = 0; b < tage_pkg::num_banks; b++) begin
            above[b] = !snap.provider_valid || (b > int'(snap.provider));
            cand[b] = above[b] && (snap.useful[b] == '0);
            // Lowest two candidates in order
            if (cand[b] && !first_found) begin
                first_found = 1'b1;
                first_cand = tage_pkg::bank_id_t'(b);
            end else if (cand[b] && !second_found) begin
                second_found = 1'b1;
                second_cand = tage_pkg::bank_id_t'(b);
            end
        end
        alloc_bank = (second_found && (lfsr < pick_second_below)) ? second_cand : first_cand;
    end

    ////////////////////
    // Write commands
    ////////////////////

    always_comb begin
        for (int b = 0; b < tage_pkg::num_banks; b++) begin
            wr_d[b] = '0;
            wr_d[b].index = snap.index[b];
            // Provider keeps its tag
            if (upd.valid && snap.provider_valid && (int'(snap.provider) == b)) begin
                wr_d[b].we = 1'b1;
                wr_d[b].entry.tag = snap.tag[b];
                wr_d[b].entry.ctr = new_ctr;
                wr_d[b].entry.useful = new_useful;
            end
            // Fresh entry with weak counter
            if (alloc_en && first_found && (int'(alloc_bank) == b)) begin
                wr_d[b].we = 1'b1;
                wr_d[b].entry.tag = snap.tag[b];
                wr_d[b].entry.ctr = upd.taken ? tage_pkg::ctr_weak_taken
                                              : tage_pkg::ctr_weak_not_taken;
                wr_d[b].entry.useful = '0;
            end
            // No free slot so wear down everything longer
            if (alloc_en && !first_found && above[b]) begin
                wr_d[b].dec_useful = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
            age_cnt <= '0;
            age_phase <= 1'b0;
            age_hi <= 1'b0;
            age_lo <= 1'b0;
            wr <= '0;
        end else begin
            lfsr <= {lfsr[6:0], lfsr_fb};
            if (upd.valid) begin
                age_cnt <= age_cnt + 1'b1;
            end
            if (age_wrap) begin
                age_phase <= ~age_phase;
            end
            age_hi <= age_wrap && !age_phase;
            age_lo <= age_wrap && age_phase;
            wr <= wr_d;
        end
    end

endmodule

/* src/tage_top.sv */
`timescale 1ns/1ps

module tage_top #(
    parameter int         UBIT_PERIOD_LOG = 8,
    parameter logic [7:0] LFSR_SEED = 8'hff
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           lookup_valid,
    input  logic [31:0]                    pc,
    input  logic [tage_pkg::hist_bits-1:0] ghist,
    output logic                           pred_valid,
    output tage_pkg::tage_pred_t           pred_out,
    input  tage_pkg::tage_update_t         upd
);

    // Hash to bank
    tage_pkg::index_t      [tage_pkg::num_banks-1:0] bank_index;
    tage_pkg::tag_t        [tage_pkg::num_banks-1:0] bank_tag;
    // Bank to selector
    tage_pkg::tage_read_t  [tage_pkg::num_banks-1:0] bank_rd;
    // Updater to bank
    tage_pkg::tage_write_t [tage_pkg::num_banks-1:0] bank_wr;
    logic age_hi;
    logic age_lo;

    ////////////////////
    // Tagged banks
    ////////////////////

    for (genvar g = 0; g < tage_pkg::num_banks; g++) begin : g_bank
        // Longer history for higher banks
        tage_fold_hash #(
            .HIST_LEN (tage_pkg::hist_len[g])
        ) u_hash (
            .pc    (pc),
            .ghist (ghist),
            .index (bank_index[g]),
            .tag   (bank_tag[g])
        );

        tage_bank u_bank (
            .clk      (clk),
            .reset    (reset),
            .rd_index (bank_index[g]),
            .rd_tag   (bank_tag[g]),
            .rd       (bank_rd[g]),
            .wr       (bank_wr[g]),
            .age_hi   (age_hi),
            .age_lo   (age_lo)
        );
    end

    ////////////////////
    // Predict and update
    ////////////////////

    tage_select u_select (
        .clk          (clk),
        .reset        (reset),
        .lookup_valid (lookup_valid),
        .rd           (bank_rd),
        .index        (bank_index),
        .tag          (bank_tag),
        .pred_valid   (pred_valid),
        .pred_out     (pred_out)
    );

    tage_update #(
        .UBIT_PERIOD_LOG (UBIT_PERIOD_LOG),
        .LFSR_SEED       (LFSR_SEED)
    ) u_update (
        .clk    (clk),
        .reset  (reset),
        .upd    (upd),
        .wr     (bank_wr),
        .age_hi (age_hi),
        .age_lo (age_lo)
    );

endmodule

/* tb/tage_model.svh */
`ifndef TAGE_MODEL_SVH
`define TAGE_MODEL_SVH

////////////////////
// Model state
////////////////////

localparam int tbl_depth = 1 << tage_pkg::index_bits;
localparam int age_period = 1 << ubit_period_log;

// Bank contents
tage_pkg::tage_entry_t tbl [tage_pkg::num_banks][tbl_depth];
// Registered read stage
tage_pkg::tage_entry_t rd_entry [tage_pkg::num_banks];
tage_pkg::index_t      rd_index [tage_pkg::num_banks];
tage_pkg::tag_t        rd_tag [tage_pkg::num_banks];
logic                  rd_valid = 1'b0;
// Commands waiting one edge before they reach the banks
tage_pkg::tage_write_t pend_wr [tage_pkg::num_banks];
logic                  pend_age_hi;
logic                  pend_age_lo;
logic [7:0]            lfsr;
int                    upd_count;
logic                  clear_low_next;
// Event counts for the summary
int                    alloc_count = 0;
int                    dec_count = 0;
int                    age_count = 0;

// Chunk fold of the first len history bits, then pc mixing
function automatic void bank_hash(input logic [31:0] pc_v,
                                  input logic [tage_pkg::hist_bits-1:0] gh,
                                  input int len,
                                  output tage_pkg::index_t idx,
                                  output tage_pkg::tag_t tg);
    logic [111:0]     h;
    tage_pkg::index_t fi;
    tage_pkg::tag_t   ft;
    h = {32'b0, gh & ({80{1'b1}} >> (80 - len))};
    fi = '0;
    ft = '0;
    for (int c = 0; c < 80; c += 7) begin
        fi ^= h[c +: 7];
    end
    for (int c = 0; c < 80; c += 8) begin
        ft ^= h[c +: 8];
    end
    idx = pc_v[8:2] ^ fi;
    // Seven bit fold shows up again, one place higher
    tg = pc_v[16:9] ^ ft ^ {fi, 1'b0};
endfunction

// Prediction from the registered reads
function automatic tage_pkg::tage_pred_t expected_pred();
    tage_pkg::tage_pred_t p;
    p = '0;
    for (int b = 0; b < tage_pkg::num_banks; b++) begin
        p.index[b] = rd_index[b];
        p.tag[b] = rd_tag[b];
        p.ctr[b] = rd_entry[b].ctr;
        p.useful[b] = rd_entry[b].useful;
    end
    // Longest bank first; tag zero is an empty slot
    for (int b = tage_pkg::num_banks - 1; b >= 0; b--) begin
        if (rd_tag[b] != '0 && rd_entry[b].tag == rd_tag[b]) begin
            if (!p.provider_valid) begin
                p.provider_valid = 1'b1;
                p.provider = tage_pkg::bank_id_t'(b);
            end else if (!p.alt_valid) begin
                p.alt_valid = 1'b1;
                p.alt = tage_pkg::bank_id_t'(b);
            end
        end
    end
    p.pred_taken = p.provider_valid && p.ctr[p.provider][tage_pkg::ctr_bits-1];
    p.alt_taken = p.alt_valid && p.ctr[p.alt][tage_pkg::ctr_bits-1];
    return p;
endfunction

// Pending writes land first, aging clear after
function automatic void apply_writes();
    tage_pkg::tage_write_t w;
    for (int b = 0; b < tage_pkg::num_banks; b++) begin
        w = pend_wr[b];
        if (w.we) begin
            tbl[b][w.index] = w.entry;
        end else if (w.dec_useful && tbl[b][w.index].useful != '0) begin
            tbl[b][w.index].useful = tbl[b][w.index].useful - 2'd1;
        end
        for (int i = 0; i < tbl_depth; i++) begin
            if (pend_age_hi) begin
                tbl[b][i].useful[1] = 1'b0;
            end
            if (pend_age_lo) begin
                tbl[b][i].useful[0] = 1'b0;
            end
        end
    end
endfunction

// Training and allocation from one commit record
function automatic void build_writes(input tage_pkg::tage_update_t u);
    tage_pkg::tage_pred_t s;
    tage_pkg::ctr_t       c;
    tage_pkg::useful_t    uf;
    logic                 miss;
    int                   prov;
    int                   first;
    int                   second;
    int                   pick;
    s = u.pred;
    miss = (u.taken != s.pred_taken);
    prov = s.provider_valid ? int'(s.provider) : -1;
    first = -1;
    second = -1;
    for (int b = 0; b < tage_pkg::num_banks; b++) begin
        pend_wr[b] = '0;
        pend_wr[b].index = s.index[b];
        // Free slots above the provider, lowest two
        if (b > prov && s.useful[b] == '0) begin
            if (first < 0) begin
                first = b;
            end else if (second < 0) begin
                second = b;
            end
        end
    end
    if (u.valid && prov >= 0) begin
        c = s.ctr[prov];
        uf = s.useful[prov];
        if (u.taken && c != 3'd7) begin
            c = c + 3'd1;
        end else if (!u.taken && c != 3'd0) begin
            c = c - 3'd1;
        end
        if (s.alt_taken != s.pred_taken) begin
            if (!miss && uf != 2'd3) begin
                uf = uf + 2'd1;
            end else if (miss && uf != 2'd0) begin
                uf = uf - 2'd1;
            end
        end
        pend_wr[prov].we = 1'b1;
        pend_wr[prov].entry.tag = s.tag[prov];
        pend_wr[prov].entry.ctr = c;
        pend_wr[prov].entry.useful = uf;
    end
    // Wrong and something longer exists
    if (u.valid && miss && prov < tage_pkg::num_banks - 1) begin
        if (first < 0) begin
            dec_count++;
            for (int b = prov + 1; b < tage_pkg::num_banks; b++) begin
                pend_wr[b].dec_useful = 1'b1;
            end
        end else begin
            pick = (second >= 0 && lfsr < 8'd170) ? second : first;
            alloc_count++;
            pend_wr[pick].we = 1'b1;
            pend_wr[pick].entry.tag = s.tag[pick];
            pend_wr[pick].entry.ctr = u.taken ? 3'd4 : 3'd3;
            pend_wr[pick].entry.useful = 2'd0;
        end
    end
endfunction

// One rising edge, given the inputs present just before it
function automatic void advance_model(input logic rst, input logic lv,
                                      input logic [31:0] pc_v,
                                      input logic [tage_pkg::hist_bits-1:0] gh,
                                      input tage_pkg::tage_update_t u);
    tage_pkg::index_t idx;
    tage_pkg::tag_t   tg;
    logic             wrap;
    // Reads see the tables from before this edge
    for (int b = 0; b < tage_pkg::num_banks; b++) begin
        bank_hash(pc_v, gh, tage_pkg::hist_len[b], idx, tg);
        rd_index[b] = idx;
        rd_tag[b] = tg;
        rd_entry[b] = tbl[b][idx];
    end
    if (rst) begin
        for (int b = 0; b < tage_pkg::num_banks; b++) begin
            for (int i = 0; i < tbl_depth; i++) begin
                tbl[b][i] = '0;
            end
            pend_wr[b] = '0;
        end
        pend_age_hi = 1'b0;
        pend_age_lo = 1'b0;
        lfsr = lfsr_seed;
        upd_count = 0;
        clear_low_next = 1'b0;
        rd_valid = 1'b0;
    end else begin
        apply_writes();
        build_writes(u);
        wrap = u.valid && (upd_count % age_period == age_period - 1);
        pend_age_hi = wrap && !clear_low_next;
        pend_age_lo = wrap && clear_low_next;
        if (wrap) begin
            clear_low_next = !clear_low_next;
            age_count++;
        end
        if (u.valid) begin
            upd_count++;
        end
        // Taps 8 6 5 4
        lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        rd_valid = lv;
    end
endfunction

`endif

/* tb/tage_tb.sv */
`timescale 1ns/1ps

module tage_tb;

    localparam int         ubit_period_log = 4;
    localparam logic [7:0] lfsr_seed = 8'hff;
    localparam int         clk_half = 5;
    localparam int         clk_period = 2 * clk_half;
    localparam int         drive_delay = 1;
    localparam int         reset_cycles = 8;
    localparam int         idle_cycles = 4;
    localparam int         num_cycles = 4000;
    localparam int         total_cycles = reset_cycles + idle_cycles + num_cycles;
    localparam int         num_branches = 16;
    localparam int         num_hists = 4;

    logic                           clk = 1'b0;
    logic                           reset;
    logic                           lookup_valid;
    logic [31:0]                    pc;
    logic [tage_pkg::hist_bits-1:0] ghist;
    logic                           pred_valid;
    tage_pkg::tage_pred_t           pred_out;
    tage_pkg::tage_update_t         upd;

    int seed;
    int cycle;
    // Branch of the lookup now in flight
    int cur_branch;
    int hits_seen;
    int alt_seen;

    // Small branch pool so entries get reused
    logic [31:0]                    pc_pool [num_branches];
    // Taken chance in sixteenths
    int                             bias [num_branches];
    logic [tage_pkg::hist_bits-1:0] hist_pool [num_hists];

    // Snapshots waiting for commit
    tage_pkg::tage_pred_t snap_q [$];
    int                   branch_q [$];
    int                   due_q [$];

    `include "tage_model.svh"

    tage_top #(
        .UBIT_PERIOD_LOG (ubit_period_log),
        .LFSR_SEED       (lfsr_seed)
    ) dut (
        .clk          (clk),
        .reset        (reset),
        .lookup_valid (lookup_valid),
        .pc           (pc),
        .ghist        (ghist),
        .pred_valid   (pred_valid),
        .pred_out     (pred_out),
        .upd          (upd)
    );

    always #clk_half clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic stop_with_failure();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at cycle %0d", cycle);
    endtask

    task automatic check_valid(input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH pred_valid: got %h expected %h at cycle %0d",
                     actual, expected, cycle);
            stop_with_failure();
        end
    endtask

    task automatic check_pred(input tage_pkg::tage_pred_t actual,
                              input tage_pkg::tage_pred_t expected);
        if (actual !== expected) begin
            $display("MISMATCH pred_out: got %h expected %h at cycle %0d",
                     actual, expected, cycle);
            stop_with_failure();
        end
    endtask

    // Next lookup plus at most one due commit
    task automatic drive_inputs();
        int br;
        lookup_valid = (rand_below(8) != 0);
        cur_branch = rand_below(num_branches);
        pc = pc_pool[cur_branch];
        ghist = hist_pool[rand_below(num_hists)];
        upd = '0;
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
            br = branch_q.pop_front();
            void'(due_q.pop_front());
            upd.valid = 1'b1;
            upd.pred = snap_q.pop_front();
            upd.taken = (rand_below(16) < bias[br]);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        seed = 32'h39fb_396d;
        reset = 1'b1;
        lookup_valid = 1'b0;
        pc = '0;
        ghist = '0;
        upd = '0;
        cur_branch = 0;
        hits_seen = 0;
        alt_seen = 0;
        for (int i = 0; i < num_branches; i++) begin
            pc_pool[i] = $random(seed) & 32'hffff_fffc;
            bias[i] = rand_below(17);
        end
        for (int h = 0; h < num_hists; h++) begin
            hist_pool[h] = {16'($random(seed)), 32'($random(seed)), 32'($random(seed))};
        end

        for (cycle = 0; cycle < total_cycles; cycle++) begin
            @(posedge clk);
            // Model sees the same inputs the DUT just sampled
            advance_model(reset, lookup_valid, pc, ghist, upd);
            #drive_delay;
            check_valid(pred_valid, rd_valid);
            if (rd_valid) begin
                check_pred(pred_out, expected_pred());
                if (pred_out.provider_valid) begin
                    hits_seen++;
                end
                if (pred_out.alt_valid) begin
                    alt_seen++;
                end
                snap_q.push_back(pred_out);
                branch_q.push_back(cur_branch);
                due_q.push_back(cycle + rand_below(4));
            end
            if (cycle >= reset_cycles - 1) begin
                reset = 1'b0;
            end
            // A few quiet cycles after reset first
            if (cycle >= reset_cycles + idle_cycles - 1) begin
                drive_inputs();
            end
        end

        $display("hits %0d alt hits %0d allocations %0d decrements %0d agings %0d",
                 hits_seen, alt_seen, alloc_count, dec_count, age_count);
        if (hits_seen == 0 || alt_seen == 0 || alloc_count == 0
                || dec_count == 0 || age_count < 2) begin
            $display({"Too little activity: hits, alternate hits, allocations, ",
                      "decrements or agings missing"});
            stop_with_failure();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

    // Hang guard
    initial begin
        #(20 * total_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d cycles", 20 * total_cycles);
        stop_with_failure();
    end

endmodule

/* sim.f */
+incdir+tb
src/tage_pkg.sv
src/tage_fold_hash.sv
src/tage_bank.sv
src/tage_select.sv
src/tage_update.sv
src/tage_top.sv
tb/tage_tb.sv

/* Makefile */
# Verilator simulation of the TAGE predictor

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       ?= tage_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status

check: run
	@grep -qF '** PASS **' $(LOG) && echo "pass message found in $(LOG)" \
		|| (echo "pass message missing from $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
